/* build.f */
+incdir+test
common/lrelu_pkg.sv
config/lrelu_config_loader.sv
datapath/lrelu_scale_stage.sv
datapath/lrelu_act_stage.sv
datapath/lrelu_requant_stage.sv
hdl/lrelu_engine.sv
test/tb_lrelu_engine.sv

/* test/lrelu_tb_tasks.svh */
// drive point, a little after the rising edge
task automatic next_cycle();
  @(posedge clk);
  #2;
endtask

task automatic fail_run(input string reason);
  $display("%s", reason);
  $display("*** TEST FAILED ***");
  $fatal(1);
endtask

task automatic check_value(input string name, input logic signed [63:0] actual,
                           input logic signed [63:0] expected);
  if (actual !== expected) begin
    fail_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected));
  end
endtask

// xorshift32
function automatic logic [31:0] next_random();
  rng_state ^= rng_state << 13;
  rng_state ^= rng_state >> 17;
  rng_state ^= rng_state << 5;
  return rng_state;
endfunction

// signed lanes of the given width, sign extended into each input word
function automatic logic [UNITS*ACC_W-1:0] random_data(input int bits);
  logic [UNITS*ACC_W-1:0] d;
  logic signed [31:0]     r;
  for (int u = 0; u < UNITS; u++) begin
    r = signed'(next_random()) >>> (32 - bits);
    d[u*ACC_W +: ACC_W] = r[ACC_W-1:0];
  end
  return d;
endfunction

// scale and bias, optional leaky slope, offset, then requantize
function automatic longint ref_lane(input longint x, input longint scale,
                                    input longint bias, input longint offset, input bit leaky);
  longint s1;
  longint s2;
  longint y;
  s1 = ((x * scale) >>> FRAC_BITS) + bias;
  if (leaky && s1 < 0) begin
    s2 = ((s1 * LRELU_ALPHA) >>> FRAC_BITS) + offset;
  end else begin
    s2 = s1 + offset;
  end
  y = s2 >>> OUT_SHIFT;
  if (y > Y_MAX) begin
    y = Y_MAX;
  end else if (y < Y_MIN) begin
    y = Y_MIN;
  end
  return y;
endfunction

// output word for the beat now at the input, using the model's channel
function automatic logic [UNITS*OUT_W-1:0] expected_beat();
  logic [UNITS*OUT_W-1:0]  y;
  logic signed [ACC_W-1:0] x;
  longint                  lane;
  for (int u = 0; u < UNITS; u++) begin
    x = s_data[u*ACC_W +: ACC_W];
    lane = ref_lane(x, scale_model[ptr_model], bias_model[ptr_model], offset_model,
                    s_user[I_IS_LRELU]);
    y[u*OUT_W +: OUT_W] = lane[OUT_W-1:0];
  end
  return y;
endfunction

task automatic reset_dut();
  rst = 1'b1;
  cfg_count = 0;
  ptr_model = 0;
  offset_model = 0;
  for (int m = 0; m < MEMBERS; m++) begin
    scale_model[m] = 0;
    bias_model[m] = 0;
  end
  repeat (3) next_cycle();
  rst = 1'b0;
endtask

// scale table, bias table, then offset, extra words ignored
task automatic send_config(input longint word);
  config_valid = 1'b1;
  config_data = config_word_t'(word);
  if (cfg_count < MEMBERS) begin
    scale_model[cfg_count] = word;
  end else if (cfg_count < 2 * MEMBERS) begin
    bias_model[cfg_count - MEMBERS] = word;
  end else if (cfg_count == 2 * MEMBERS) begin
    offset_model = word;
  end
  if (cfg_count <= 2 * MEMBERS) begin
    cfg_count++;
  end
  next_cycle();
  config_valid = 1'b0;
endtask

task automatic pulse_clear();
  config_clear = 1'b1;
  cfg_count = 0;
  ptr_model = 0;
  next_cycle();
  config_clear = 1'b0;
endtask

task automatic send_beat(input logic [UNITS*ACC_W-1:0] data, input logic last,
                         input user_t user);
  s_valid = 1'b1;
  s_data = data;
  s_last = last;
  s_user = user;
  next_cycle();
  s_valid = 1'b0;
endtask

task automatic wait_drained();
  int waited;
  waited = 0;
  while (exp_data.size() != 0) begin
    if (waited == 20) begin
      fail_run("timed out waiting for the pipeline to drain");
    end else begin
      next_cycle();
      waited++;
    end
  end
endtask

/* test/tb_lrelu_engine.sv */
module tb_lrelu_engine import lrelu_pkg::*; ();

  localparam int     ACC_W   = 24;
  localparam int     OUT_W   = 8;
  localparam int     UNITS   = 4;
  localparam int     MEMBERS = 4;
  localparam longint Y_MAX   = 2 ** (OUT_W - 1) - 1;
  localparam longint Y_MIN   = -(2 ** (OUT_W - 1));

  logic                   clk;
  logic                   rst;
  logic                   clken;
  logic                   s_valid;
  logic                   s_last;
  user_t                  s_user;
  logic [UNITS*ACC_W-1:0] s_data;
  logic                   config_clear;
  logic                   config_valid;
  config_word_t           config_data;
  logic                   m_valid;
  logic                   m_last;
  user_t                  m_user;
  logic [UNITS*OUT_W-1:0] m_data;
  logic                   config_full;

  // reference model of the tables and the read pointer
  longint      scale_model [MEMBERS];
  longint      bias_model  [MEMBERS];
  longint      offset_model;
  int          cfg_count;
  int          ptr_model;
  int          cycles;
  logic [31:0] rng_state = 32'd49756;

  // beats in flight, oldest first
  logic [UNITS*OUT_W-1:0] exp_data  [$];
  logic                   exp_last  [$];
  user_t                  exp_user  [$];
  int                     exp_cycle [$];

  logic                   held_valid;
  logic                   held_last;
  user_t                  held_user;
  logic [UNITS*OUT_W-1:0] held_data;

  `include "lrelu_tb_tasks.svh"

  lrelu_engine lrelu_engine_inst (.*);

  always #20 clk = ~clk;

  // output monitor, samples once the edge has settled
  always @(posedge clk) begin
    #1;
    if (rst) begin
      exp_data.delete();
      exp_last.delete();
      exp_user.delete();
      exp_cycle.delete();
      cycles = 0;
    end else if (clken) begin
      cycles++;
      if (m_valid) begin
        if (exp_data.size() == 0) begin
          fail_run("output beat appeared with no matching input beat");
        end else begin
          check_value("latency", cycles - exp_cycle.pop_front(), 3);
          check_value("m_last", m_last, exp_last.pop_front());
          check_value("m_user", m_user, exp_user.pop_front());
          check_value("m_data", m_data, exp_data.pop_front());
        end
      end else if (exp_data.size() != 0 && cycles - exp_cycle[0] >= 3) begin
        fail_run("expected output beat did not appear");
      end
      if (s_valid) begin
        exp_data.push_back(expected_beat());
        exp_last.push_back(s_last);
        exp_user.push_back(s_user);
        // the beat was presented in the cycle that just ended
        exp_cycle.push_back(cycles - 1);
        ptr_model = (ptr_model + 1) % MEMBERS;
      end
    end else begin
      // stalled, nothing may move
      check_value("m_valid", m_valid, held_valid);
      check_value("m_last", m_last, held_last);
      check_value("m_user", m_user, held_user);
      check_value("m_data", m_data, held_data);
    end
    held_valid = m_valid;
    held_last = m_last;
    held_user = m_user;
    held_data = m_data;
  end

  task automatic test_config_load();
    check_value("config_full", config_full, 0);
    for (int k = 0; k < 2 * MEMBERS; k++) begin
      send_config(k < MEMBERS ? 256 + 32 * k : 40 * k - 200);
    end
    check_value("config_full", config_full, 0);
    send_config(96);
    check_value("config_full", config_full, 1);
    send_config(1234);
    // extra word is dropped, still full
    check_value("config_full", config_full, 1);
    pulse_clear();
    check_value("config_full", config_full, 0);
  endtask

  task automatic test_random_stream(input bit leaky);
    user_t user;
    for (int n = 0; n < 12; n++) begin
      user = user_t'(next_random());
      user[I_IS_LRELU] = leaky;
      send_beat(random_data(15), n == 11, user);
    end
    wait_drained();
  endtask

  // distinct channels, more beats than one pass through the tables
  task automatic test_cyclic();
    pulse_clear();
    for (int k = 0; k < MEMBERS; k++) begin
      send_config((k % 2 == 0) ? 128 + 96 * k : -64 - 80 * k);
    end
    for (int k = 0; k < MEMBERS; k++) begin
      send_config(1000 * k - 1500);
    end
    send_config(-32);
    check_value("config_full", config_full, 1);
    for (int n = 0; n < 2 * MEMBERS + 1; n++) begin
      send_beat(random_data(14), n == 2 * MEMBERS, user_t'(n));
    end
    wait_drained();
  endtask

  task automatic test_saturation();
    send_beat({24'hc00000, 24'h400000, 24'h800000, 24'h7fffff}, 1'b0, user_t'(0));
    send_beat({24'h7fffff, 24'h800000, 24'h400000, 24'hc00000}, 1'b1, user_t'(1));
    wait_drained();
  endtask

  task automatic test_stall();
    for (int n = 0; n < 6; n++) begin
      if (n == 3) begin
        clken = 1'b0;
        s_valid = 1'b1;
        s_data = random_data(15);
        repeat (5) next_cycle();
        clken = 1'b1;
      end
      send_beat(random_data(15), n == 5, user_t'(n));
    end
    wait_drained();
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    clken = 1'b1;
    s_valid = 1'b0;
    s_last = 1'b0;
    s_user = '0;
    s_data = '0;
    config_clear = 1'b0;
    config_valid = 1'b0;
    config_data = '0;
    reset_dut();
    check_value("m_valid", m_valid, 0);
    check_value("m_last", m_last, 0);
    test_config_load();
    test_random_stream(1'b0);
    test_random_stream(1'b1);
    // leaves the read pointer mid table before the clear
    test_saturation();
    test_cyclic();
    test_stall();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* hdl/lrelu_engine.sv */
module lrelu_engine import lrelu_pkg::*; #(
  parameter int WORD_WIDTH_ACC = 24,
  parameter int WORD_WIDTH     = 8,
  parameter int UNITS          = 4,
  parameter int MEMBERS        = 4
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            clken,
  input  logic                            s_valid,
  input  logic                            s_last,
  input  user_t                           s_user,
  input  logic [UNITS*WORD_WIDTH_ACC-1:0] s_data,
  input  logic                            config_clear,
  input  logic                            config_valid,
  input  config_word_t                    config_data,
  output logic                            m_valid,
  output logic                            m_last,
  output user_t                           m_user,
  output logic [UNITS*WORD_WIDTH-1:0]     m_data,
  output logic                            config_full
);

  // coefficients for the beat at the input
  config_word_t coef_scale;
  config_word_t coef_bias;
  config_word_t coef_offset;

  // scale stage to activation stage
  logic              s1_valid;
  logic              s1_last;
  user_t             s1_user;
  prod_t [UNITS-1:0] s1_data;

  // activation stage to requant stage
  logic              s2_valid;
  logic              s2_last;
  user_t             s2_user;
  prod_t [UNITS-1:0] s2_data;

  lrelu_config_loader #(
    .MEMBERS (MEMBERS)
  ) lrelu_config_loader_inst (
    .clk          (clk),
    .rst          (rst),
    .clken        (clken),
    .config_clear (config_clear),
    .config_valid (config_valid),
    .config_data  (config_data),
    .s_valid      (s_valid),
    .config_full  (config_full),
    .coef_scale   (coef_scale),
    .coef_bias    (coef_bias),
    .coef_offset  (coef_offset)
  );

  lrelu_scale_stage #(
    .WORD_WIDTH_ACC (WORD_WIDTH_ACC),
    .UNITS          (UNITS)
  ) lrelu_scale_stage_inst (
    .clk        (clk),
    .rst        (rst),
    .clken      (clken),
    .s_valid    (s_valid),
    .s_last     (s_last),
    .s_user     (s_user),
    .s_data     (s_data),
    .coef_scale (coef_scale),
    .coef_bias  (coef_bias),
    .m_valid    (s1_valid),
    .m_last     (s1_last),
    .m_user     (s1_user),
    .m_data     (s1_data)
  );

  lrelu_act_stage #(
    .UNITS (UNITS)
  ) lrelu_act_stage_inst (
    .clk         (clk),
    .rst         (rst),
    .clken       (clken),
    .s_valid     (s1_valid),
    .s_last      (s1_last),
    .s_user      (s1_user),
    .s_data      (s1_data),
    .coef_offset (coef_offset),
    .m_valid     (s2_valid),
    .m_last      (s2_last),
    .m_user      (s2_user),
    .m_data      (s2_data)
  );

  lrelu_requant_stage #(
    .UNITS      (UNITS),
    .WORD_WIDTH (WORD_WIDTH)
  ) lrelu_requant_stage_inst (
    .clk     (clk),
    .rst     (rst),
    .clken   (clken),
    .s_valid (s2_valid),
    .s_last  (s2_last),
    .s_user  (s2_user),
    .s_data  (s2_data),
    .m_valid (m_valid),
    .m_last  (m_last),
    .m_user  (m_user),
    .m_data  (m_data)
  );

endmodule

/* datapath/lrelu_requant_stage.sv */
module lrelu_requant_stage import lrelu_pkg::*; #(
  parameter int UNITS      = 4,
  parameter int WORD_WIDTH = 8
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        clken,
  input  logic                        s_valid,
  input  logic                        s_last,
  input  user_t                       s_user,
  input  prod_t [UNITS-1:0]           s_data,
  output logic                        m_valid,
  output logic                        m_last,
  output user_t                       m_user,
  output logic [UNITS*WORD_WIDTH-1:0] m_data
);

  // signed range of the output word
  localparam prod_t OUT_MAX = (prod_t'(1) <<< (WORD_WIDTH - 1)) - prod_t'(1);
  localparam prod_t OUT_MIN = -(prod_t'(1) <<< (WORD_WIDTH - 1));

  logic [UNITS*WORD_WIDTH-1:0] lane_res;

  for (genvar u = 0; u < UNITS; u++) begin : g_lane
    prod_t shifted;
    prod_t clamped;

    assign shifted = s_data[u] >>> OUT_SHIFT;

    always_comb begin
      if (shifted > OUT_MAX) begin
        clamped = OUT_MAX;
      end else if (shifted < OUT_MIN) begin
        clamped = OUT_MIN;
      end else begin
        clamped = shifted;
      end
    end

    assign lane_res[u*WORD_WIDTH +: WORD_WIDTH] = clamped[WORD_WIDTH-1:0];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      m_valid <= 1'b0;
      m_last  <= 1'b0;
    end else if (clken) begin
      m_valid <= s_valid;
      m_last  <= s_last;
    end
  end

  always_ff @(posedge clk) begin
    if (clken) begin
      m_user <= s_user;
      m_data <= lane_res;
    end
  end

endmodule

/* datapath/lrelu_act_stage.sv */
module lrelu_act_stage import lrelu_pkg::*; #(
  parameter int UNITS = 4
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              clken,
  input  logic              s_valid,
  input  logic              s_last,
  input  user_t             s_user,
  input  prod_t [UNITS-1:0] s_data,
  input  config_word_t      coef_offset,
  output logic              m_valid,
  output logic              m_last,
  output user_t             m_user,
  output prod_t [UNITS-1:0] m_data
);

  prod_t [UNITS-1:0] lane_res;
  logic              is_lrelu;

  // leaky only when the beat asks for it
  assign is_lrelu = s_user[I_IS_LRELU];

  for (genvar u = 0; u < UNITS; u++) begin : g_lane
    prod_t sloped;
    prod_t act;

    assign sloped = (s_data[u] * prod_t'(LRELU_ALPHA)) >>> FRAC_BITS;

    // sign bit picks the slope, positives pass as is
    assign act = (is_lrelu && s_data[u][PROD_WIDTH-1]) ? sloped : s_data[u];

    assign lane_res[u] = act + prod_t'(coef_offset);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      m_valid <= 1'b0;
      m_last  <= 1'b0;
    end else if (clken) begin
      m_valid <= s_valid;
      m_last  <= s_last;
    end
  end

  always_ff @(posedge clk) begin
    if (clken) begin
      m_user <= s_user;
      m_data <= lane_res;
    end
  end

endmodule

/* datapath/lrelu_scale_stage.sv */
module lrelu_scale_stage import lrelu_pkg::*; #(
  parameter int WORD_WIDTH_ACC = 24,
  parameter int UNITS          = 4
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            clken,
  input  logic                            s_valid,
  input  logic                            s_last,
  input  user_t                           s_user,
  input  logic [UNITS*WORD_WIDTH_ACC-1:0] s_data,
  input  config_word_t                    coef_scale,
  input  config_word_t                    coef_bias,
  output logic                            m_valid,
  output logic                            m_last,
  output user_t                           m_user,
  output prod_t [UNITS-1:0]               m_data
);

  prod_t [UNITS-1:0] lane_res;

  for (genvar u = 0; u < UNITS; u++) begin : g_lane
    prod_t x;
    prod_t prod;

    // lane 0 sits in the low bits
    assign x    = prod_t'(signed'(s_data[u*WORD_WIDTH_ACC +: WORD_WIDTH_ACC]));
    assign prod = x * prod_t'(coef_scale);

    // floor shift drops the Q8 fraction of the scale
    assign lane_res[u] = (prod >>> FRAC_BITS) + prod_t'(coef_bias);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      m_valid <= 1'b0;
      m_last  <= 1'b0;
    end else if (clken) begin
      m_valid <= s_valid;
      m_last  <= s_last;
    end
  end

  always_ff @(posedge clk) begin
    if (clken) begin
      m_user <= s_user;
      m_data <= lane_res;
    end
  end

endmodule

/* config/lrelu_config_loader.sv */
module lrelu_config_loader import lrelu_pkg::*; #(
  parameter int MEMBERS = 4
) (
  input  logic         clk,
  input  logic         rst,
  input  logic         clken,
  input  logic         config_clear,
  input  logic         config_valid,
  input  config_word_t config_data,
  input  logic         s_valid,
  output logic         config_full,
  output config_word_t coef_scale,
  output config_word_t coef_bias,
  output config_word_t coef_offset
);

  // scale table, bias table, then one offset word
  localparam int CONFIG_WORDS = 2 * MEMBERS + 1;
  localparam int CNT_WIDTH    = $clog2(CONFIG_WORDS + 1);
  localparam int PTR_WIDTH    = (MEMBERS > 1) ? $clog2(MEMBERS) : 1;

  logic [CNT_WIDTH-1:0] count;
  logic [PTR_WIDTH-1:0] ptr;
  logic                 clear;
  logic                 take;
  config_word_t         scale_tab [MEMBERS];
  config_word_t         bias_tab  [MEMBERS];
  config_word_t         offset;

  assign clear = clken && config_clear;

  // words after the offset are dropped until the next clear
  assign take = clken && config_valid && !config_clear && !config_full;

  // counter stops at CONFIG_WORDS, which is the full state
  always_ff @(posedge clk) begin
    if (rst || clear) begin
      count <= '0;
    end else if (take) begin
      count <= count + 1'b1;
    end
  end

  assign config_full = (count == CNT_WIDTH'(CONFIG_WORDS));

  // word k lands in scale[k], then bias[k - MEMBERS], then offset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int m = 0; m < MEMBERS; m++) begin
        scale_tab[m] <= '0;
        bias_tab[m]  <= '0;
      end
      offset <= '0;
    end else if (take) begin
      for (int m = 0; m < MEMBERS; m++) begin
        if (count == CNT_WIDTH'(m)) begin
          scale_tab[m] <= config_data;
        end
        if (count == CNT_WIDTH'(MEMBERS + m)) begin
          bias_tab[m] <= config_data;
        end
      end
      if (count == CNT_WIDTH'(2 * MEMBERS)) begin
        offset <= config_data;
      end
    end
  end

  // cyclic read pointer, one channel per accepted data beat
  always_ff @(posedge clk) begin
    if (rst || clear) begin
      ptr <= '0;
    end else if (clken && s_valid) begin
      if (ptr == PTR_WIDTH'(MEMBERS - 1)) begin
        ptr <= '0;
      end else begin
        ptr <= ptr + 1'b1;
      end
    end
  end

  // combinational, so the beat at the input sees its own channel
  assign coef_scale  = scale_tab[ptr];
  assign coef_bias   = bias_tab[ptr];
  assign coef_offset = offset;

endmodule

/* common/lrelu_pkg.sv */
package lrelu_pkg;

  // config stream word, carries a scale, a bias or the offset
  localparam int CONFIG_WIDTH = 16;

  typedef logic signed [CONFIG_WIDTH-1:0] config_word_t;

  // scale and alpha are both Q8
  localparam int FRAC_BITS = 8;

  // leaky slope, 26/256 is roughly 0.1
  localparam int LRELU_ALPHA = 26;

  // wide enough for a 30 bit input times a 16 bit scale
  localparam int PROD_WIDTH = 48;

  typedef logic signed [PROD_WIDTH-1:0] prod_t;

  // internal scale down to output scale
  localparam int OUT_SHIFT = 8;

  // user sideband, travels with each beat
  localparam int TUSER_WIDTH = 4;

  typedef logic [TUSER_WIDTH-1:0] user_t;

  // leaky enable flag inside the user sideband
  localparam int I_IS_LRELU = 0;

endpackage
